// ==== rp_top.f ====
+incdir+tb
verilog/rp_sig_pkg.sv
verilog/rp_bus_pkg.sv
verilog/adc_frontend.sv
verilog/dac_backend.sv
verilog/sys_bus_decoder.sv
verilog/housekeeping_regs.sv
verilog/output_level_regs.sv
verilog/rp_top.sv
tb/rp_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rp_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f rp_top.f --top-module rp_top_tb -o rp_top_sim

./obj_dir/rp_top_sim > sim.log 2>&1
cat sim.log

if grep -q "All checks passed" sim.log; then
  exit 0
fi
echo "simulation reported failures, see sim.log"
exit 1

// ==== tb/rp_model.svh ====
`ifndef RP_MODEL_SVH
`define RP_MODEL_SVH

//////////////////////////////
// reference model
//////////////////////////////

// pins are offset binary with a negative slope, so only the sign survives unflipped
function automatic logic [13:0] model_adc(input logic [15:0] raw);
  logic [13:0] word;
  word = raw[15:2];            // bits 1:0 reserved
  return word ^ 14'h1fff;
endfunction

// level plus offset as integers, clamped to the 14 bit range
function automatic int model_sat_sum(input logic [13:0] lvl, input logic [13:0] ofs);
  int s;
  s = int'($signed(lvl)) + int'($signed(ofs));
  if (s > 8191) begin
    s = 8191;
  end else if (s < -8192) begin
    s = -8192;
  end
  return s;
endfunction

// negative slope dac code of a clamped sample
function automatic logic [13:0] model_dac(input int s);
  logic [13:0] word;
  word = s[13:0];
  return word ^ 14'h1fff;      // zero maps to mid scale
endfunction

function automatic logic [31:0] model_sext(input logic [13:0] v);
  return {{18{v[13]}}, v};
endfunction

// err expected for this address, two channels assumed
function automatic logic model_err(input logic [31:0] addr);
  logic [2:0]  region;
  logic [11:0] off;
  region = addr[22:20];
  off    = addr[11:0];
  if (region > 3'd1) return 1'b1;                              // nothing mapped there
  if (addr[31:23] != '0 || addr[19:12] != '0) return 1'b1;     // stray bits past the offset
  if (region == 3'd0) return !(off inside {12'h000, 12'h004, 12'h008, 12'h010, 12'h014});
  return !(off inside {12'h000, 12'h004, 12'h008, 12'h00c});   // level block
endfunction

`endif

// ==== tb/rp_top_tb.sv ====
`timescale 1ns/1ps

module rp_top_tb;

  localparam int NUM_CH      = 2;
  localparam int CYCLE_LIMIT = 4000;  // roughly twice what all tests need

  logic                               adc_clk;
  logic                               top_rst;
  rp_sig_pkg::adc_raw_t  [NUM_CH-1:0] adc_dat;
  rp_bus_pkg::sys_req_t               bus_req;
  rp_bus_pkg::sys_rsp_t               bus_rsp;
  rp_sig_pkg::dac_code_t [NUM_CH-1:0] dac_dat;
  logic [7:0]                         led;

  logic [31:0] rng = 32'hf30562d8;    // xorshift state
  int          cycles = 0;
  int          checks = 0;
  int          fails = 0;
  int          test_checks;
  int          test_fails;
  logic [31:0] exp_q[$];              // pending compares
  logic [31:0] act_q[$];
  string       name_q[$];
  string       cur_name;
  logic [31:0] cur_exp;
  logic [31:0] cur_act;

  `include "rp_model.svh"

  rp_top #(.NUM_CH(NUM_CH)) dut0 (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .dac_dat_o (dac_dat),
    .led_o     (led)
  );

  always #5 adc_clk = ~adc_clk;  // 10 ns period

  //////////////////////////////
  // compare and timeout
  //////////////////////////////

  always @(negedge adc_clk) begin
    while (exp_q.size() > 0) begin
      cur_exp  = exp_q.pop_front();
      cur_act  = act_q.pop_front();
      cur_name = name_q.pop_front();
      checks++;
      assert (cur_act === cur_exp) else begin
        $display("Mismatch %s: expected %h, actual %h", cur_name, cur_exp, cur_act);
        fails++;
      end
    end
  end

  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, tests still running after %0d cycles", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // half the draws sit near a rail
  function automatic logic [13:0] rand_sample();
    logic [31:0] r;
    r = next_rand();
    case (r[31:30])
      2'd0:    return 14'h1fff - 14'(r[3:0]);  // near +8191
      2'd1:    return 14'h2000 + 14'(r[3:0]);  // near -8192
      default: return r[13:0];
    endcase
  endfunction

  function automatic logic [31:0] reg_addr(input int region, input int off);
    return (32'(region) << rp_bus_pkg::REGION_LSB) | 32'(off);
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    exp_q.push_back(exp);
    act_q.push_back(act);
    name_q.push_back(name);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
    #1;
  endtask

  task automatic start_test();
    test_checks = checks;
    test_fails  = fails;
  endtask

  task automatic end_test(input string name);
    while (exp_q.size() > 0) wait_cycles(1);  // let the checker drain
    $display("test %-10s %0d checks, %0d failed", name, checks - test_checks, fails - test_fails);
  endtask

  // one request cycle with ack expected on the next edge only
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata, input logic wr,
                            output logic [31:0] rdata, output logic err);
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    bus_req.wen   = wr;
    bus_req.ren   = !wr;
    @(posedge adc_clk);
    #1;
    bus_req.wen = 1'b0;
    bus_req.ren = 1'b0;
    rdata       = bus_rsp.rdata;
    err         = bus_rsp.err;
    checks++;
    assert (bus_rsp.ack === 1'b1) else begin
      $display("no ack one cycle after the request to address %h", addr);
      fails++;
    end
    wait_cycles(1);
    checks++;
    assert (bus_rsp.ack === 1'b0) else begin
      $display("ack for address %h stayed high longer than one cycle", addr);
      fails++;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata, output logic err);
    logic [31:0] unused;
    bus_access(addr, wdata, 1'b1, unused, err);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata, output logic err);
    bus_access(addr, 32'h0, 1'b0, rdata, err);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  // unused offsets and one address with a stray bit above the offset field
  localparam logic [31:0] ODD_ADDR [5] = '{32'h0000_000c, 32'h0000_0018, 32'h0010_0010,
                                           32'h0010_0040, 32'h0000_1004};

  initial begin
    logic [31:0] rd;
    logic        er;
    logic [13:0] lv [NUM_CH];
    logic [13:0] of [NUM_CH];
    logic [7:0]  led_val;
    adc_clk = 1'b0;
    top_rst = 1'b1;
    adc_dat = '0;
    bus_req = '0;
    repeat (8) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;

    start_test();
    for (int ch = 0; ch < NUM_CH; ch++) expect_eq("reset dac", 32'h1fff, 32'(dac_dat[ch]));
    expect_eq("reset led", 32'h0, 32'(led));
    bus_read(reg_addr(0, 'h0), rd, er);
    expect_eq("reset id", rp_bus_pkg::HK_ID_VALUE, rd);
    bus_read(reg_addr(0, 'h4), rd, er);
    expect_eq("reset loop", 32'h0, rd);
    end_test("reset");

    start_test();
    repeat (50) begin
      for (int ch = 0; ch < NUM_CH; ch++) adc_dat[ch] = 16'(next_rand());
      wait_cycles(3);  // pins to read-back takes two edges
      for (int ch = 0; ch < NUM_CH; ch++) begin
        bus_read(reg_addr(0, 'h10 + 4 * ch), rd, er);
        expect_eq($sformatf("adc ch%0d", ch), model_sext(model_adc(adc_dat[ch])), rd);
      end
    end
    end_test("adc");

    start_test();
    repeat (50) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        lv[ch] = rand_sample();
        of[ch] = rand_sample();
        bus_write(reg_addr(1, 8 * ch), {18'(next_rand()), lv[ch]}, er);  // upper bits dropped
        bus_write(reg_addr(1, 8 * ch + 4), {18'(next_rand()), of[ch]}, er);
      end
      wait_cycles(2);
      for (int ch = 0; ch < NUM_CH; ch++) begin
        expect_eq($sformatf("dac ch%0d", ch), 32'(model_dac(model_sat_sum(lv[ch], of[ch]))),
                  32'(dac_dat[ch]));
        bus_read(reg_addr(1, 8 * ch), rd, er);
        expect_eq($sformatf("level ch%0d", ch), model_sext(lv[ch]), rd);
        bus_read(reg_addr(1, 8 * ch + 4), rd, er);
        expect_eq($sformatf("offset ch%0d", ch), model_sext(of[ch]), rd);
      end
    end
    end_test("dac");

    start_test();
    bus_write(reg_addr(0, 'h4), 32'h1, er);
    bus_read(reg_addr(0, 'h4), rd, er);
    expect_eq("loop flag", 32'h1, rd);
    repeat (10) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        lv[ch] = rand_sample();
        of[ch] = rand_sample();
        bus_write(reg_addr(1, 8 * ch), 32'(lv[ch]), er);
        bus_write(reg_addr(1, 8 * ch + 4), 32'(of[ch]), er);
      end
      wait_cycles(3);
      for (int ch = 0; ch < NUM_CH; ch++) begin
        adc_dat[ch] = 16'(next_rand());  // pins must not leak through
        bus_read(reg_addr(0, 'h10 + 4 * ch), rd, er);
        expect_eq($sformatf("loop ch%0d", ch), model_sext(14'(model_sat_sum(lv[ch], of[ch]))),
                  rd);
      end
    end
    bus_write(reg_addr(0, 'h4), 32'h0, er);
    end_test("loopback");

    start_test();
    for (int rg = 2; rg < 8; rg++) begin
      bus_read(reg_addr(rg, 'h0), rd, er);
      expect_eq("region read err", 32'(model_err(reg_addr(rg, 'h0))), 32'(er));
      bus_write(reg_addr(rg, 'h4), next_rand(), er);
      expect_eq("region write err", 32'(model_err(reg_addr(rg, 'h4))), 32'(er));
    end
    foreach (ODD_ADDR[i]) begin
      bus_read(ODD_ADDR[i], rd, er);
      expect_eq("offset read err", 32'(model_err(ODD_ADDR[i])), 32'(er));
      bus_write(ODD_ADDR[i], 32'h0, er);
      expect_eq("offset write err", 32'(model_err(ODD_ADDR[i])), 32'(er));
    end
    led_val = 8'(next_rand());
    bus_write(reg_addr(0, 'h8), {24'hffffff, led_val}, er);
    expect_eq("led write err", 32'h0, 32'(er));
    expect_eq("led pins", 32'(led_val), 32'(led));
    bus_write(reg_addr(0, 'h0), 32'hdead_beef, er);  // id is read only
    expect_eq("id write err", 32'h0, 32'(er));
    bus_read(reg_addr(0, 'h0), rd, er);
    expect_eq("id after write", rp_bus_pkg::HK_ID_VALUE, rd);
    expect_eq("led after id write", 32'(led_val), 32'(led));
    end_test("errors");

    $display("%0d checks, %0d failed", checks, fails);
    if (fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== verilog/adc_frontend.sv ====
`timescale 1ns/1ps

module adc_frontend #(
  parameter int NUM_CH = 2
) (
  input  logic                                adc_clk,
  input  logic                                top_rst,
  input  rp_sig_pkg::adc_raw_t [NUM_CH-1:0]   adc_dat_i,  // straight from the pins
  input  logic                                loop_i,     // digital loopback
  input  rp_sig_pkg::sample_t  [NUM_CH-1:0]   sat_i,      // clamped dac value
  output rp_sig_pkg::sample_t  [NUM_CH-1:0]   sample_o
);

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch

    rp_sig_pkg::adc_raw_t raw_q;     // io register
    rp_sig_pkg::sample_t  conv;      // two's complement of raw_q
    rp_sig_pkg::sample_t  sample_q;

    //////////////////////////////
    // pin capture
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
      raw_q <= adc_dat_i[ch];  // low two bits ride along unused
    end

    // offset binary, negative slope -> signed
    assign conv = rp_sig_pkg::adc_to_sample(raw_q);

    //////////////////////////////
    // loopback select
    //////////////////////////////

    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        sample_q <= '0;
      end else begin
        // loopback bypasses the converter completely
        sample_q <= loop_i ? sat_i[ch] : conv;
      end
    end

    assign sample_o[ch] = sample_q;

  end : g_ch

endmodule

// ==== verilog/dac_backend.sv ====
`timescale 1ns/1ps

module dac_backend #(
  parameter int NUM_CH = 2
) (
  input  logic                                 adc_clk,
  input  logic                                 top_rst,
  input  rp_sig_pkg::sample_t   [NUM_CH-1:0]   level_i,    // generator stand-in
  input  rp_sig_pkg::sample_t   [NUM_CH-1:0]   offset_i,   // controller stand-in
  output rp_sig_pkg::sample_t   [NUM_CH-1:0]   sat_o,      // clamped sum, combinational
  output rp_sig_pkg::dac_code_t [NUM_CH-1:0]   dac_dat_o   // one word per channel
);

  localparam int SW = rp_sig_pkg::SAMPLE_W;
  localparam int UW = rp_sig_pkg::SUM_W;

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch

    rp_sig_pkg::sum_t      sum;    // one bit wider than a sample
    logic                  ovf;    // top two bits disagree
    rp_sig_pkg::dac_code_t dac_q;

    //////////////////////////////
    // sum and clamp
    //////////////////////////////

    // both operands sign extended by hand
    assign sum = {level_i[ch][SW-1], level_i[ch]} + {offset_i[ch][SW-1], offset_i[ch]};

    assign ovf = sum[UW-1] ^ sum[UW-2];

    // sign of the sum picks the rail
    assign sat_o[ch] = ovf ? (sum[UW-1] ? rp_sig_pkg::SAT_MIN : rp_sig_pkg::SAT_MAX)
                           : sum[SW-1:0];

    //////////////////////////////
    // output register
    //////////////////////////////

    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        dac_q <= rp_sig_pkg::DAC_ZERO;  // mid scale, 14'h1fff
      end else begin
        dac_q <= rp_sig_pkg::sample_to_dac(sat_o[ch]);
      end
    end

    assign dac_dat_o[ch] = dac_q;

  end : g_ch

endmodule

// ==== verilog/housekeeping_regs.sv ====
`timescale 1ns/1ps

module housekeeping_regs #(
  parameter int NUM_CH = 2
) (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  input  rp_bus_pkg::sys_req_t               req_i,
  output rp_bus_pkg::sys_rsp_t               rsp_o,
  input  rp_sig_pkg::sample_t [NUM_CH-1:0]   sample_i,  // adc read-back
  output logic                               loop_o,    // digital loopback
  output logic [7:0]                         led_o
);

  localparam int AW = $bits(rp_bus_pkg::bus_addr_t);
  localparam int DW = $bits(rp_bus_pkg::bus_data_t);
  localparam int OW = rp_bus_pkg::OFFSET_W;
  localparam int SW = rp_sig_pkg::SAMPLE_W;

  rp_bus_pkg::offset_t   off;
  logic                  in_blk;   // nothing set above the offset field
  logic                  req_vld;
  logic                  hit;      // offset is mapped
  rp_bus_pkg::bus_data_t rdata;
  logic                  loop_q;
  logic [7:0]            led_q;
  logic                  ack_q;
  logic                  err_q;
  rp_bus_pkg::bus_data_t rdata_q;

  assign off     = req_i.addr[OW-1:0];
  assign in_blk  = ~|req_i.addr[AW-1:OW];
  assign req_vld = req_i.wen | req_i.ren;

  //////////////////////////////
  // read decode
  //////////////////////////////

  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (off)
      rp_bus_pkg::HK_ID:   rdata = rp_bus_pkg::HK_ID_VALUE;
      rp_bus_pkg::HK_LOOP: rdata = {{(DW-1){1'b0}}, loop_q};
      rp_bus_pkg::HK_LED:  rdata = {{(DW-8){1'b0}}, led_q};
      default: begin
        hit = 1'b0;
        // one sample word per channel
        for (int ch = 0; ch < NUM_CH; ch++) begin
          if (off == rp_bus_pkg::offset_t'(rp_bus_pkg::HK_ADC_BASE +
                                           ch * rp_bus_pkg::HK_ADC_STRIDE)) begin
            hit   = 1'b1;
            rdata = {{(DW-SW){sample_i[ch][SW-1]}}, sample_i[ch]};  // sign extend
          end
        end
      end
    endcase
    hit = hit & in_blk;
  end

  // writable registers, id and samples ignore writes
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      loop_q <= 1'b0;
      led_q  <= '0;
    end else if (req_i.wen && in_blk) begin
      if (off == rp_bus_pkg::HK_LOOP) begin
        loop_q <= req_i.wdata[0];
      end
      if (off == rp_bus_pkg::HK_LED) begin
        led_q <= req_i.wdata[7:0];
      end
    end
  end

  //////////////////////////////
  // response
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_vld;         // always answer next cycle
      err_q <= req_vld & ~hit;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (req_i.ren) begin
      rdata_q <= rdata;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = err_q;
  assign loop_o      = loop_q;
  assign led_o       = led_q;

endmodule

// ==== verilog/output_level_regs.sv ====
`timescale 1ns/1ps

module output_level_regs #(
  parameter int NUM_CH = 2
) (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  input  rp_bus_pkg::sys_req_t               req_i,
  output rp_bus_pkg::sys_rsp_t               rsp_o,
  output rp_sig_pkg::sample_t [NUM_CH-1:0]   level_o,
  output rp_sig_pkg::sample_t [NUM_CH-1:0]   offset_o
);

  localparam int AW = $bits(rp_bus_pkg::bus_addr_t);
  localparam int DW = $bits(rp_bus_pkg::bus_data_t);
  localparam int OW = rp_bus_pkg::OFFSET_W;
  localparam int SW = rp_sig_pkg::SAMPLE_W;

  rp_bus_pkg::offset_t              off;
  logic                             in_blk;
  logic                             req_vld;
  logic                             hit;
  logic [NUM_CH-1:0]                lvl_sel;   // level register addressed
  logic [NUM_CH-1:0]                ofs_sel;   // offset register addressed
  rp_bus_pkg::bus_data_t            rdata;
  rp_sig_pkg::sample_t [NUM_CH-1:0] level_q;
  rp_sig_pkg::sample_t [NUM_CH-1:0] offset_q;
  logic                             ack_q;
  logic                             err_q;
  rp_bus_pkg::bus_data_t            rdata_q;

  assign off     = req_i.addr[OW-1:0];
  assign in_blk  = ~|req_i.addr[AW-1:OW];
  assign req_vld = req_i.wen | req_i.ren;

  //////////////////////////////
  // decode, stride 8 per channel
  //////////////////////////////

  always_comb begin
    rdata = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      lvl_sel[ch] = in_blk && (off == rp_bus_pkg::offset_t'(ch * rp_bus_pkg::LVL_STRIDE +
                                                           rp_bus_pkg::LVL_LEVEL));
      ofs_sel[ch] = in_blk && (off == rp_bus_pkg::offset_t'(ch * rp_bus_pkg::LVL_STRIDE +
                                                           rp_bus_pkg::LVL_OFFSET));
      if (lvl_sel[ch]) begin
        rdata = {{(DW-SW){level_q[ch][SW-1]}}, level_q[ch]};
      end
      if (ofs_sel[ch]) begin
        rdata = {{(DW-SW){offset_q[ch][SW-1]}}, offset_q[ch]};
      end
    end
    hit = |{lvl_sel, ofs_sel};  // past the last channel -> err
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      level_q  <= '0;
      offset_q <= '0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (req_i.wen && lvl_sel[ch]) level_q[ch]  <= req_i.wdata[SW-1:0];  // low 14 bits
        if (req_i.wen && ofs_sel[ch]) offset_q[ch] <= req_i.wdata[SW-1:0];
      end
      ack_q <= req_vld;
      err_q <= req_vld & ~hit;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (req_i.ren) begin
      rdata_q <= rdata;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = err_q;
  assign level_o     = level_q;
  assign offset_o    = offset_q;

endmodule

// ==== verilog/rp_bus_pkg.sv ====
package rp_bus_pkg;

  typedef logic [31:0] bus_addr_t;  // byte address
  typedef logic [31:0] bus_data_t;

  typedef struct packed {
    bus_addr_t addr;
    bus_data_t wdata;
    logic      wen;    // single cycle pulse
    logic      ren;    // single cycle pulse
  } sys_req_t;

  typedef struct packed {
    bus_data_t rdata;  // valid together with ack
    logic      ack;
    logic      err;    // unmapped region or offset
  } sys_rsp_t;

  //////////////////////////////
  // address map
  //////////////////////////////

  localparam int REGION_LSB = 20;
  localparam int REGION_W   = 3;                // eight regions
  typedef logic [REGION_W-1:0] region_t;
  localparam region_t REGION_HK    = 3'd0;
  localparam region_t REGION_LEVEL = 3'd1;

  localparam int OFFSET_W = 12;                 // offset inside a region
  typedef logic [OFFSET_W-1:0] offset_t;

  // housekeeping block
  localparam offset_t HK_ID         = 12'h000;
  localparam offset_t HK_LOOP       = 12'h004;
  localparam offset_t HK_LED        = 12'h008;
  localparam offset_t HK_ADC_BASE   = 12'h010;  // channel 0 sample
  localparam offset_t HK_ADC_STRIDE = 12'h004;

  // output level block, one pair per channel
  localparam offset_t LVL_STRIDE = 12'h008;
  localparam offset_t LVL_LEVEL  = 12'h000;
  localparam offset_t LVL_OFFSET = 12'h004;

  localparam bus_data_t HK_ID_VALUE = 32'h5250_0a14;

endpackage

// ==== verilog/rp_sig_pkg.sv ====
package rp_sig_pkg;

  //////////////////////////////
  // widths of the analog path
  //////////////////////////////

  localparam int SAMPLE_W = 14;                // converter resolution
  localparam int RAW_W    = 16;                // adc pin word
  localparam int RAW_LSB  = RAW_W - SAMPLE_W;  // reserved low pin bits
  localparam int SUM_W    = SAMPLE_W + 1;      // one guard bit for the adder

  typedef logic        [RAW_W-1:0]    adc_raw_t;   // offset binary, negative slope
  typedef logic signed [SAMPLE_W-1:0] sample_t;    // two's complement
  typedef logic        [SAMPLE_W-1:0] dac_code_t;  // offset binary, negative slope
  typedef logic signed [SUM_W-1:0]    sum_t;       // level + offset before clamping

  // clamp limits, 8191 and -8192
  localparam sample_t SAT_MAX = sample_t'({1'b0, {(SAMPLE_W-1){1'b1}}});
  localparam sample_t SAT_MIN = sample_t'({1'b1, {(SAMPLE_W-1){1'b0}}});

  localparam dac_code_t DAC_ZERO = {1'b0, {(SAMPLE_W-1){1'b1}}};  // code of a zero sample

  // pin word to sample, msb kept, the rest flipped
  function automatic sample_t adc_to_sample(adc_raw_t raw);
    return {raw[RAW_W-1], ~raw[RAW_W-2:RAW_LSB]};
  endfunction

  // sample back to the negative slope code
  function automatic dac_code_t sample_to_dac(sample_t s);
    return {s[SAMPLE_W-1], ~s[SAMPLE_W-2:0]};
  endfunction

endpackage

// ==== verilog/rp_top.sv ====
`timescale 1ns/1ps

module rp_top #(
  parameter int NUM_CH = 2
) (
  input  logic                                 adc_clk,
  input  logic                                 top_rst,
  input  rp_sig_pkg::adc_raw_t  [NUM_CH-1:0]   adc_dat_i,
  input  rp_bus_pkg::sys_req_t                 bus_req_i,
  output rp_bus_pkg::sys_rsp_t                 bus_rsp_o,
  output rp_sig_pkg::dac_code_t [NUM_CH-1:0]   dac_dat_o,
  output logic [7:0]                           led_o
);

  //////////////////////////////
  // local wires
  //////////////////////////////

  rp_bus_pkg::sys_req_t             hk_req;     // region 0
  rp_bus_pkg::sys_rsp_t             hk_rsp;
  rp_bus_pkg::sys_req_t             lvl_req;    // region 1
  rp_bus_pkg::sys_rsp_t             lvl_rsp;
  rp_sig_pkg::sample_t [NUM_CH-1:0] level;
  rp_sig_pkg::sample_t [NUM_CH-1:0] offset;
  rp_sig_pkg::sample_t [NUM_CH-1:0] dac_sat;    // loopback source
  rp_sig_pkg::sample_t [NUM_CH-1:0] adc_dat;
  logic                             digital_loop;

  adc_frontend #(.NUM_CH(NUM_CH)) adc0 (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .loop_i    (digital_loop),
    .sat_i     (dac_sat),
    .sample_o  (adc_dat)
  );

  dac_backend #(.NUM_CH(NUM_CH)) dac0 (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .level_i   (level),
    .offset_i  (offset),
    .sat_o     (dac_sat),
    .dac_dat_o (dac_dat_o)
  );

  //////////////////////////////
  // system bus
  //////////////////////////////

  sys_bus_decoder dec0 (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp),
    .lvl_req_o (lvl_req),
    .lvl_rsp_i (lvl_rsp)
  );

  housekeeping_regs #(.NUM_CH(NUM_CH)) hk0 (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .req_i    (hk_req),
    .rsp_o    (hk_rsp),
    .sample_i (adc_dat),
    .loop_o   (digital_loop),
    .led_o    (led_o)
  );

  output_level_regs #(.NUM_CH(NUM_CH)) lvl0 (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .req_i    (lvl_req),
    .rsp_o    (lvl_rsp),
    .level_o  (level),
    .offset_o (offset)
  );

endmodule

// ==== verilog/sys_bus_decoder.sv ====
`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // master side
  input  rp_bus_pkg::sys_req_t bus_req_i,
  output rp_bus_pkg::sys_rsp_t bus_rsp_o,
  // region 0, housekeeping
  output rp_bus_pkg::sys_req_t hk_req_o,
  input  rp_bus_pkg::sys_rsp_t hk_rsp_i,
  // region 1, output levels
  output rp_bus_pkg::sys_req_t lvl_req_o,
  input  rp_bus_pkg::sys_rsp_t lvl_rsp_i
);

  localparam int RL = rp_bus_pkg::REGION_LSB;
  localparam int RW = rp_bus_pkg::REGION_W;

  rp_bus_pkg::region_t  region;      // region of the incoming request
  rp_bus_pkg::region_t  region_q;    // region owed a response
  rp_bus_pkg::sys_req_t req_fwd;     // request with the region field cleared
  logic                 req_vld;
  logic                 hk_sel;
  logic                 lvl_sel;
  logic                 stub_ack_q;  // own answer for regions 2..7

  assign region  = bus_req_i.addr[RL +: RW];
  assign req_vld = bus_req_i.wen | bus_req_i.ren;
  assign hk_sel  = (region == rp_bus_pkg::REGION_HK);
  assign lvl_sel = (region == rp_bus_pkg::REGION_LEVEL);

  //////////////////////////////
  // request fan-out
  //////////////////////////////

  always_comb begin
    req_fwd              = bus_req_i;
    req_fwd.addr[RL +: RW] = '0;  // slaves see offsets only

    hk_req_o      = req_fwd;
    hk_req_o.wen  = req_fwd.wen & hk_sel;
    hk_req_o.ren  = req_fwd.ren & hk_sel;

    lvl_req_o     = req_fwd;
    lvl_req_o.wen = req_fwd.wen & lvl_sel;
    lvl_req_o.ren = req_fwd.ren & lvl_sel;
  end

  // remember who answers on the next cycle
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      region_q   <= rp_bus_pkg::REGION_HK;
      stub_ack_q <= 1'b0;
    end else begin
      if (req_vld) begin
        region_q <= region;
      end
      stub_ack_q <= req_vld & ~hk_sel & ~lvl_sel;
    end
  end

  //////////////////////////////
  // response mux
  //////////////////////////////

  always_comb begin
    case (region_q)
      rp_bus_pkg::REGION_HK:    bus_rsp_o = hk_rsp_i;
      rp_bus_pkg::REGION_LEVEL: bus_rsp_o = lvl_rsp_i;
      default: begin
        bus_rsp_o.rdata = '0;
        bus_rsp_o.ack   = stub_ack_q;
        bus_rsp_o.err   = stub_ack_q;  // nothing lives here
      end
    endcase
  end

endmodule
